// ==== lsq_subsystem.f ====
source/ooo_isa_pkg.sv
source/lsq_mem_pkg.sv
source/ls_queue.sv
source/ls_unit.sv
source/data_mem_axil.sv
source/lsq_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_lsq_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the load/store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f lsq_subsystem.f \
    --top-module tb_lsq_subsystem

out=$(./obj_dir/Vtb_lsq_subsystem)
echo "$out"

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
else
    exit 1
fi

// ==== source/data_mem_axil.sv ====
`default_nettype none

module data_mem_axil (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [ooo_isa_pkg::xlen-1:0] awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [ooo_isa_pkg::xlen-1:0] wdata,
    input  logic [3:0]                   wstrb,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic                         arvalid,
    output logic                         arready,
    input  logic [ooo_isa_pkg::xlen-1:0] araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [ooo_isa_pkg::xlen-1:0] rdata
);

    logic [ooo_isa_pkg::xlen-1:0] mem [lsq_mem_pkg::mem_words];

    logic pending;
    logic wr_go;
    logic rd_go;
    logic [lsq_mem_pkg::mem_addr_len-1:0] wr_idx;
    logic [lsq_mem_pkg::mem_addr_len-1:0] rd_idx;

    // word index sits above the byte offset
    assign wr_idx = awaddr[lsq_mem_pkg::mem_addr_len+1:2];
    assign rd_idx = araddr[lsq_mem_pkg::mem_addr_len+1:2];

    // one outstanding response at a time
    assign pending = bvalid || rvalid;

    // write wins when both arrive together
    assign wr_go = awvalid && wvalid && !pending;
    assign rd_go = arvalid && arready;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = !pending && !(awvalid && wvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        if (rd_go) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== source/ls_queue.sv ====
`default_nettype none

module ls_queue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                dispatch,
    input  ooo_isa_pkg::ls_func_e               disp_func,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] disp_rob_tag,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] disp_tag_src1,
    input  logic                                disp_ready_src1,
    input  logic [ooo_isa_pkg::xlen-1:0]        disp_value_src1,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] disp_tag_src2,
    input  logic                                disp_ready_src2,
    input  logic [ooo_isa_pkg::xlen-1:0]        disp_value_src2,
    input  logic [ooo_isa_pkg::xlen-1:0]        disp_imm,
    input  logic                                commit_store,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] commit_rob_tag,
    input  logic                                valid_forwarding,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] forwarding_rob_tag,
    input  logic [ooo_isa_pkg::xlen-1:0]        forwarding_data,
    input  logic                                issue_ready,
    input  logic                                ls_done,
    output logic                                full,
    output logic                                issue_valid,
    output ooo_isa_pkg::ls_func_e               issue_func,
    output logic [ooo_isa_pkg::rob_tag_len-1:0] issue_rob_tag,
    output logic [ooo_isa_pkg::xlen-1:0]        issue_base,
    output logic [ooo_isa_pkg::xlen-1:0]        issue_imm,
    output logic [ooo_isa_pkg::xlen-1:0]        issue_store_data
);

    // per-entry control
    logic                                e_valid     [lsq_mem_pkg::lsq_size];
    logic                                e_issued    [lsq_mem_pkg::lsq_size];
    logic                                e_committed [lsq_mem_pkg::lsq_size];
    logic                                e_ready1    [lsq_mem_pkg::lsq_size];
    logic                                e_ready2    [lsq_mem_pkg::lsq_size];
    // per-entry payload
    ooo_isa_pkg::ls_func_e               e_func      [lsq_mem_pkg::lsq_size];
    logic [ooo_isa_pkg::rob_tag_len-1:0] e_rob_tag   [lsq_mem_pkg::lsq_size];
    logic [ooo_isa_pkg::rob_tag_len-1:0] e_tag1      [lsq_mem_pkg::lsq_size];
    logic [ooo_isa_pkg::rob_tag_len-1:0] e_tag2      [lsq_mem_pkg::lsq_size];
    logic [ooo_isa_pkg::xlen-1:0]        e_value1    [lsq_mem_pkg::lsq_size];
    logic [ooo_isa_pkg::xlen-1:0]        e_value2    [lsq_mem_pkg::lsq_size];
    logic [ooo_isa_pkg::xlen-1:0]        e_imm       [lsq_mem_pkg::lsq_size];

    logic [lsq_mem_pkg::lsq_ptr_len:0]   head;
    logic [lsq_mem_pkg::lsq_ptr_len:0]   tail;
    logic [lsq_mem_pkg::lsq_ptr_len-1:0] head_idx;
    logic [lsq_mem_pkg::lsq_ptr_len-1:0] tail_idx;

    logic disp_fire;
    logic issue_fire;
    logic done_ok;
    logic fwd_src1;
    logic fwd_src2;
    // set while a flushed access is still in the unit
    logic stale_done;

    assign head_idx = head[lsq_mem_pkg::lsq_ptr_len-1:0];
    assign tail_idx = tail[lsq_mem_pkg::lsq_ptr_len-1:0];

    // same index, opposite wrap bit
    assign full = (head_idx == tail_idx)
                  && (head[lsq_mem_pkg::lsq_ptr_len] != tail[lsq_mem_pkg::lsq_ptr_len]);

    assign issue_valid = e_valid[head_idx] && !e_issued[head_idx] && e_ready1[head_idx]
                         && ((e_func[head_idx] != ooo_isa_pkg::LS_STORE)
                             || (e_ready2[head_idx] && e_committed[head_idx]));

    assign issue_func       = e_func[head_idx];
    assign issue_rob_tag    = e_rob_tag[head_idx];
    assign issue_base       = e_value1[head_idx];
    assign issue_imm        = e_imm[head_idx];
    assign issue_store_data = e_value2[head_idx];

    assign disp_fire  = dispatch && !full;
    assign issue_fire = issue_valid && issue_ready;
    assign done_ok    = ls_done && !stale_done;

    // wake-up on the dispatch cycle itself
    assign fwd_src1 = valid_forwarding && !disp_ready_src1 && (disp_tag_src1 == forwarding_rob_tag);
    assign fwd_src2 = valid_forwarding && !disp_ready_src2 && (disp_tag_src2 == forwarding_rob_tag);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < lsq_mem_pkg::lsq_size; i++) begin
                e_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < lsq_mem_pkg::lsq_size; i++) begin
                if (e_valid[i] && valid_forwarding) begin
                    if (!e_ready1[i] && (e_tag1[i] == forwarding_rob_tag)) begin
                        e_ready1[i] <= 1'b1;
                        e_value1[i] <= forwarding_data;
                    end
                    if (!e_ready2[i] && (e_tag2[i] == forwarding_rob_tag)) begin
                        e_ready2[i] <= 1'b1;
                        e_value2[i] <= forwarding_data;
                    end
                end
                if (e_valid[i] && commit_store && (e_func[i] == ooo_isa_pkg::LS_STORE)
                    && (e_rob_tag[i] == commit_rob_tag)) begin
                    e_committed[i] <= 1'b1;
                end
            end

            if (issue_fire) begin
                e_issued[head_idx] <= 1'b1;
            end

            // retire head once the unit reports completion
            if (done_ok) begin
                e_valid[head_idx] <= 1'b0;
                head <= head + 1'b1;
            end

            if (disp_fire) begin
                e_valid[tail_idx]     <= 1'b1;
                e_issued[tail_idx]    <= 1'b0;
                e_committed[tail_idx] <= 1'b0;
                e_func[tail_idx]      <= disp_func;
                e_rob_tag[tail_idx]   <= disp_rob_tag;
                e_tag1[tail_idx]      <= disp_tag_src1;
                e_tag2[tail_idx]      <= disp_tag_src2;
                e_ready1[tail_idx]    <= disp_ready_src1 || fwd_src1;
                e_ready2[tail_idx]    <= disp_ready_src2 || fwd_src2;
                e_value1[tail_idx]    <= fwd_src1 ? forwarding_data : disp_value_src1;
                e_value2[tail_idx]    <= fwd_src2 ? forwarding_data : disp_value_src2;
                e_imm[tail_idx]       <= disp_imm;
                tail <= tail + 1'b1;
            end
        end
    end

    // an access issued before flush still returns ls_done, which must not retire a new head
    always_ff @(posedge clk) begin
        if (rst) begin
            stale_done <= 1'b0;
        end else if (flush) begin
            stale_done <= issue_fire
                          || (e_valid[head_idx] && e_issued[head_idx] && !ls_done)
                          || (stale_done && !ls_done);
        end else if (ls_done) begin
            stale_done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/ls_unit.sv ====
`default_nettype none

module ls_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue_valid,
    input  ooo_isa_pkg::ls_func_e               issue_func,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] issue_rob_tag,
    input  logic [ooo_isa_pkg::xlen-1:0]        issue_base,
    input  logic [ooo_isa_pkg::xlen-1:0]        issue_imm,
    input  logic [ooo_isa_pkg::xlen-1:0]        issue_store_data,
    output logic                                issue_ready,
    output logic                                ls_done,
    output logic                                result_valid,
    output logic [ooo_isa_pkg::rob_tag_len-1:0] result_rob_tag,
    output logic [ooo_isa_pkg::xlen-1:0]        result_data,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [ooo_isa_pkg::xlen-1:0]        awaddr,
    output logic                                wvalid,
    input  logic                                wready,
    output logic [ooo_isa_pkg::xlen-1:0]        wdata,
    output logic [3:0]                          wstrb,
    input  logic                                bvalid,
    output logic                                bready,
    output logic                                arvalid,
    input  logic                                arready,
    output logic [ooo_isa_pkg::xlen-1:0]        araddr,
    input  logic                                rvalid,
    output logic                                rready,
    input  logic [ooo_isa_pkg::xlen-1:0]        rdata
);

    lsq_mem_pkg::ls_state_e state;

    // latched operation
    ooo_isa_pkg::ls_func_e               op_func;
    logic [ooo_isa_pkg::rob_tag_len-1:0] op_rob_tag;
    logic [ooo_isa_pkg::xlen-1:0]        op_addr;
    logic [ooo_isa_pkg::xlen-1:0]        op_data;

    // store address and data may be accepted in different cycles
    logic aw_done;
    logic w_done;

    logic op_load;
    logic addr_ok;
    logic resp_fire;
    logic [7:0]                   rd_byte;
    logic [ooo_isa_pkg::xlen-1:0] load_value;

    assign op_load     = (op_func != ooo_isa_pkg::LS_STORE);
    assign issue_ready = (state == lsq_mem_pkg::LS_IDLE);

    assign arvalid = (state == lsq_mem_pkg::LS_ADDR) && op_load;
    assign awvalid = (state == lsq_mem_pkg::LS_ADDR) && !op_load && !aw_done;
    assign wvalid  = (state == lsq_mem_pkg::LS_ADDR) && !op_load && !w_done;
    assign rready  = (state == lsq_mem_pkg::LS_RESP) && op_load;
    assign bready  = (state == lsq_mem_pkg::LS_RESP) && !op_load;

    assign araddr = op_addr;
    assign awaddr = op_addr;
    assign wdata  = op_data;
    assign wstrb  = 4'hf;

    assign addr_ok = op_load ? (arvalid && arready)
                             : ((aw_done || (awvalid && awready))
                                && (w_done || (wvalid && wready)));
    assign resp_fire = op_load ? (rvalid && rready) : (bvalid && bready);

    // byte lane from the low address bits
    assign rd_byte    = rdata[{op_addr[1:0], 3'b000} +: 8];
    assign load_value = (op_func == ooo_isa_pkg::LS_LOADU)
                        ? {{(ooo_isa_pkg::xlen-8){1'b0}}, rd_byte} : rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= lsq_mem_pkg::LS_IDLE;
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            ls_done      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            ls_done      <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                lsq_mem_pkg::LS_IDLE: begin
                    if (issue_valid) begin
                        state   <= lsq_mem_pkg::LS_ADDR;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                lsq_mem_pkg::LS_ADDR: begin
                    if (awvalid && awready) begin
                        aw_done <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        w_done <= 1'b1;
                    end
                    if (addr_ok) begin
                        state <= lsq_mem_pkg::LS_RESP;
                    end
                end
                lsq_mem_pkg::LS_RESP: begin
                    if (resp_fire) begin
                        state        <= lsq_mem_pkg::LS_IDLE;
                        ls_done      <= 1'b1;
                        result_valid <= op_load;
                    end
                end
                default: state <= lsq_mem_pkg::LS_IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            op_func    <= issue_func;
            op_rob_tag <= issue_rob_tag;
            op_addr    <= issue_base + issue_imm;
            op_data    <= issue_store_data;
        end
        if (resp_fire) begin
            result_rob_tag <= op_rob_tag;
            result_data    <= load_value;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsq_mem_pkg.sv ====
`default_nettype none

// queue and data memory configuration
package lsq_mem_pkg;

    // queue depth and index width, pointers carry one extra wrap bit
    localparam int lsq_size    = 8;
    localparam int lsq_ptr_len = 3;

    // word memory behind the AXI4-Lite port
    localparam int mem_words    = 256;
    localparam int mem_addr_len = 8;

    // load/store unit sequencing
    typedef enum logic [1:0] {
        LS_IDLE = 2'd0,
        LS_ADDR = 2'd1,
        LS_RESP = 2'd2
    } ls_state_e;

endpackage

`default_nettype wire

// ==== source/lsq_subsystem.sv ====
`default_nettype none

module lsq_subsystem (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                dispatch,
    input  ooo_isa_pkg::ls_func_e               disp_func,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] disp_rob_tag,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] disp_tag_src1,
    input  logic                                disp_ready_src1,
    input  logic [ooo_isa_pkg::xlen-1:0]        disp_value_src1,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] disp_tag_src2,
    input  logic                                disp_ready_src2,
    input  logic [ooo_isa_pkg::xlen-1:0]        disp_value_src2,
    input  logic [ooo_isa_pkg::xlen-1:0]        disp_imm,
    input  logic                                commit_store,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] commit_rob_tag,
    input  logic                                valid_forwarding,
    input  logic [ooo_isa_pkg::rob_tag_len-1:0] forwarding_rob_tag,
    input  logic [ooo_isa_pkg::xlen-1:0]        forwarding_data,
    output logic                                full,
    output logic                                result_valid,
    output logic [ooo_isa_pkg::rob_tag_len-1:0] result_rob_tag,
    output logic [ooo_isa_pkg::xlen-1:0]        result_data
);

    // queue to unit
    logic                                issue_valid;
    logic                                issue_ready;
    ooo_isa_pkg::ls_func_e               issue_func;
    logic [ooo_isa_pkg::rob_tag_len-1:0] issue_rob_tag;
    logic [ooo_isa_pkg::xlen-1:0]        issue_base;
    logic [ooo_isa_pkg::xlen-1:0]        issue_imm;
    logic [ooo_isa_pkg::xlen-1:0]        issue_store_data;
    logic                                ls_done;

    // AXI4-Lite between unit and memory
    logic                         awvalid, awready, wvalid, wready;
    logic                         bvalid, bready, arvalid, arready;
    logic                         rvalid, rready;
    logic [ooo_isa_pkg::xlen-1:0] awaddr, wdata, araddr, rdata;
    logic [3:0]                   wstrb;

    ls_queue u_queue (
        .clk, .rst, .flush, .dispatch, .disp_func, .disp_rob_tag,
        .disp_tag_src1, .disp_ready_src1, .disp_value_src1,
        .disp_tag_src2, .disp_ready_src2, .disp_value_src2, .disp_imm,
        .commit_store, .commit_rob_tag,
        .valid_forwarding, .forwarding_rob_tag, .forwarding_data,
        .issue_ready, .ls_done, .full, .issue_valid, .issue_func,
        .issue_rob_tag, .issue_base, .issue_imm, .issue_store_data
    );

    ls_unit u_unit (
        .clk, .rst, .issue_valid, .issue_func, .issue_rob_tag,
        .issue_base, .issue_imm, .issue_store_data, .issue_ready, .ls_done,
        .result_valid, .result_rob_tag, .result_data,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
    );

    data_mem_axil u_mem (
        .clk, .rst, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
    );

endmodule

`default_nettype wire

// ==== source/ooo_isa_pkg.sv ====
`default_nettype none

// instruction-level widths and opcodes shared across the core
package ooo_isa_pkg;

    // data and address width
    localparam int xlen = 32;

    // reorder buffer tag, also used for operand tags
    localparam int rob_tag_len = 5;

    // memory operations handled by the load/store path
    typedef enum logic [1:0] {
        LS_LOAD  = 2'd0,
        LS_LOADU = 2'd1,
        LS_STORE = 2'd2
    } ls_func_e;

endpackage

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 20 time unit period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_lsq_subsystem.sv ====
`default_nettype none

module tb_lsq_subsystem;

    typedef logic [ooo_isa_pkg::xlen-1:0] word_t;
    typedef logic [ooo_isa_pkg::rob_tag_len-1:0] tag_t;
    typedef struct packed {
        tag_t  tag;
        word_t data;
    } result_t;

    // roughly ten times the longest test
    localparam int max_cycles = 4000;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  dispatch;
    ooo_isa_pkg::ls_func_e disp_func;
    tag_t                  disp_rob_tag;
    tag_t                  disp_tag_src1;
    logic                  disp_ready_src1;
    word_t                 disp_value_src1;
    tag_t                  disp_tag_src2;
    logic                  disp_ready_src2;
    word_t                 disp_value_src2;
    word_t                 disp_imm;
    logic                  commit_store;
    tag_t                  commit_rob_tag;
    logic                  valid_forwarding;
    tag_t                  forwarding_rob_tag;
    word_t                 forwarding_data;
    logic                  full;
    logic                  result_valid;
    tag_t                  result_rob_tag;
    word_t                 result_data;

    // memory image, written word indices, loads awaiting their result
    word_t   ref_mem [lsq_mem_pkg::mem_words];
    int      written_q [$];
    result_t exp_q [$];
    result_t popped;

    logic [31:0] rng_state = 32'hc0a6438d;
    // rob tags handed out in program order
    tag_t  next_tag = '0;
    string test_name = "reset";
    int    errors = 0;
    int    err_mark = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycles = 0;

    tb_clock_gen clock_gen (
        .clk(clk),
        .rst(rst)
    );

    lsq_subsystem uut (
        .clk, .rst, .flush, .dispatch, .disp_func, .disp_rob_tag,
        .disp_tag_src1, .disp_ready_src1, .disp_value_src1,
        .disp_tag_src2, .disp_ready_src2, .disp_value_src2, .disp_imm,
        .commit_store, .commit_rob_tag,
        .valid_forwarding, .forwarding_rob_tag, .forwarding_data,
        .full, .result_valid, .result_rob_tag, .result_data
    );

    function automatic word_t next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [lsq_mem_pkg::mem_addr_len-1:0] word_index(input word_t addr);
        return addr[lsq_mem_pkg::mem_addr_len+1:2];
    endfunction

    function automatic word_t random_word_addr();
        return (next_rand() % word_t'(lsq_mem_pkg::mem_words)) << 2;
    endfunction

    // only words already stored may be read back
    function automatic word_t pick_written();
        int idx;
        idx = int'(next_rand() % word_t'(written_q.size()));
        return word_t'(written_q[idx]) << 2;
    endfunction

    function automatic tag_t alloc_tag();
        tag_t tag;
        tag = next_tag;
        next_tag = next_tag + tag_t'(1);
        return tag;
    endfunction

    // expected load value from the model memory
    function automatic word_t expected_load(input ooo_isa_pkg::ls_func_e func, input word_t addr);
        word_t word;
        word = ref_mem[word_index(addr)];
        if (func == ooo_isa_pkg::LS_LOADU) begin
            // lane n is bits 8n+7 down to 8n, upper bits zero
            word = (word >> (8 * addr[1:0])) & 32'h0000_00ff;
        end
        return word;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic split_addr(input word_t addr, output word_t base, output word_t imm);
        imm  = (next_rand() % 16) << 2;
        base = addr - imm;
    endtask

    // one entry per call, never raised while the queue is full
    task automatic dispatch_op(
        input ooo_isa_pkg::ls_func_e func,
        input tag_t                  rob_tag,
        input tag_t                  tag1,
        input logic                  rdy1,
        input word_t                 val1,
        input tag_t                  tag2,
        input logic                  rdy2,
        input word_t                 val2,
        input word_t                 imm
    );
        @(negedge clk);
        while (full) @(negedge clk);
        @(posedge clk);
        dispatch        <= 1'b1;
        disp_func       <= func;
        disp_rob_tag    <= rob_tag;
        disp_tag_src1   <= tag1;
        disp_ready_src1 <= rdy1;
        disp_value_src1 <= val1;
        disp_tag_src2   <= tag2;
        disp_ready_src2 <= rdy2;
        disp_value_src2 <= val2;
        disp_imm        <= imm;
        @(posedge clk);
        dispatch <= 1'b0;
    endtask

    task automatic commit_pulse(input tag_t tag);
        @(posedge clk);
        commit_store   <= 1'b1;
        commit_rob_tag <= tag;
        @(posedge clk);
        commit_store <= 1'b0;
    endtask

    task automatic forward_pulse(input tag_t tag, input word_t data);
        @(posedge clk);
        valid_forwarding   <= 1'b1;
        forwarding_rob_tag <= tag;
        forwarding_data    <= data;
        @(posedge clk);
        valid_forwarding <= 1'b0;
    endtask

    task automatic flush_pulse();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // model memory follows program order, so it is updated at dispatch
    task automatic store_word(input word_t addr, input word_t data, input logic commit,
                              output tag_t tag);
        word_t base;
        word_t imm;
        split_addr(addr, base, imm);
        tag = alloc_tag();
        dispatch_op(ooo_isa_pkg::LS_STORE, tag, '0, 1'b1, base, '0, 1'b1, data, imm);
        ref_mem[word_index(addr)] = data;
        written_q.push_back(int'(word_index(addr)));
        if (commit) begin
            commit_pulse(tag);
        end
    endtask

    task automatic load_op(input ooo_isa_pkg::ls_func_e func, input word_t addr);
        word_t   base;
        word_t   imm;
        result_t entry;
        split_addr(addr, base, imm);
        entry.tag = alloc_tag();
        entry.data = expected_load(func, addr);
        dispatch_op(func, entry.tag, '0, 1'b1, base, '0, 1'b1, '0, imm);
        exp_q.push_back(entry);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        while (exp_q.size() != 0) @(negedge clk);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s finished with no errors", test_name);
        end else begin
            tests_failed++;
            $display("test %s finished with %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic store_then_load();
        word_t addrs [6];
        tag_t  tag;
        for (int i = 0; i < 6; i++) begin
            addrs[i] = random_word_addr();
            store_word(addrs[i], next_rand(), 1'b1, tag);
        end
        for (int i = 0; i < 6; i++) begin
            load_op(ooo_isa_pkg::LS_LOAD, addrs[i]);
        end
    endtask

    task automatic byte_loads();
        for (int off = 0; off < 4; off++) begin
            load_op(ooo_isa_pkg::LS_LOADU, pick_written() + word_t'(off));
        end
        for (int i = 0; i < 4; i++) begin
            load_op(ooo_isa_pkg::LS_LOADU, pick_written() + (next_rand() % 4));
        end
    endtask

    task automatic operand_wakeup();
        word_t   addr;
        word_t   base;
        word_t   imm;
        word_t   data;
        tag_t    ftag;
        tag_t    stag;
        result_t entry;
        // load waits for its base
        addr = pick_written();
        split_addr(addr, base, imm);
        ftag = tag_t'(next_rand());
        entry.tag = alloc_tag();
        entry.data = expected_load(ooo_isa_pkg::LS_LOAD, addr);
        dispatch_op(ooo_isa_pkg::LS_LOAD, entry.tag, ftag, 1'b0, '0, '0, 1'b1, '0, imm);
        exp_q.push_back(entry);
        repeat (4) @(posedge clk);
        forward_pulse(ftag, base);
        // store waits for its data
        addr = random_word_addr();
        data = next_rand();
        split_addr(addr, base, imm);
        ftag = tag_t'(next_rand());
        stag = alloc_tag();
        dispatch_op(ooo_isa_pkg::LS_STORE, stag, '0, 1'b1, base, ftag, 1'b0, '0, imm);
        commit_pulse(stag);
        forward_pulse(ftag, data);
        ref_mem[word_index(addr)] = data;
        written_q.push_back(int'(word_index(addr)));
        load_op(ooo_isa_pkg::LS_LOAD, addr);
    endtask

    task automatic commit_gating();
        word_t addr;
        tag_t  stag;
        addr = pick_written();
        store_word(addr, next_rand(), 1'b0, stag);
        load_op(ooo_isa_pkg::LS_LOAD, addr);
        // uncommitted store at the head holds back the load
        repeat (20) @(negedge clk);
        check_value({test_name, " pending loads"}, 1, word_t'(exp_q.size()));
        commit_pulse(stag);
    endtask

    task automatic fill_queue();
        tag_t stag;
        store_word(pick_written(), next_rand(), 1'b0, stag);
        for (int i = 0; i < lsq_mem_pkg::lsq_size - 2; i++) begin
            if (i % 2 == 0) begin
                load_op(ooo_isa_pkg::LS_LOAD, pick_written());
            end else begin
                load_op(ooo_isa_pkg::LS_LOADU, pick_written() + (next_rand() % 4));
            end
        end
        @(negedge clk);
        check_value({test_name, " full at seven"}, 0, word_t'(full));
        load_op(ooo_isa_pkg::LS_LOAD, pick_written());
        @(negedge clk);
        check_value({test_name, " full at eight"}, 1, word_t'(full));
        commit_pulse(stag);
    endtask

    task automatic flush_pending();
        word_t addr;
        word_t base;
        word_t imm;
        tag_t  tag;
        addr = pick_written();
        // this load issues before the flush, so its result still comes back
        load_op(ooo_isa_pkg::LS_LOAD, addr);
        flush_pulse();
        // store that never commits, and a load stuck behind it
        split_addr(addr, base, imm);
        dispatch_op(ooo_isa_pkg::LS_STORE, alloc_tag(), '0, 1'b1, base, '0, 1'b1,
                    ~ref_mem[word_index(addr)], imm);
        dispatch_op(ooo_isa_pkg::LS_LOAD, alloc_tag(), '0, 1'b1, base, '0, 1'b1, '0, imm);
        flush_pulse();
        load_op(ooo_isa_pkg::LS_LOAD, addr);
        addr = random_word_addr();
        store_word(addr, next_rand(), 1'b1, tag);
        load_op(ooo_isa_pkg::LS_LOAD, addr);
    endtask

    // results must come back in program order
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("error in %s: load result for rob tag %0d arrived with no load pending",
                         test_name, result_rob_tag);
                errors++;
            end else begin
                popped = exp_q.pop_front();
                check_value({test_name, " rob tag"}, word_t'(popped.tag), word_t'(result_rob_tag));
                check_value({test_name, " load data"}, popped.data, result_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        flush              = 1'b0;
        dispatch           = 1'b0;
        disp_func          = ooo_isa_pkg::LS_LOAD;
        disp_rob_tag       = '0;
        disp_tag_src1      = '0;
        disp_ready_src1    = 1'b0;
        disp_value_src1    = '0;
        disp_tag_src2      = '0;
        disp_ready_src2    = 1'b0;
        disp_value_src2    = '0;
        disp_imm           = '0;
        commit_store       = 1'b0;
        commit_rob_tag     = '0;
        valid_forwarding   = 1'b0;
        forwarding_rob_tag = '0;
        forwarding_data    = '0;
        @(negedge clk);
        while (rst) @(negedge clk);
        start_test("store_then_load");
        store_then_load();
        end_test();
        start_test("byte_loads");
        byte_loads();
        end_test();
        start_test("operand_wakeup");
        operand_wakeup();
        end_test();
        start_test("commit_gating");
        commit_gating();
        end_test();
        start_test("fill_queue");
        fill_queue();
        end_test();
        start_test("flush_pending");
        flush_pending();
        end_test();
        // catch late results from flushed entries
        repeat (10) @(negedge clk);
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
